// ==== hdl/fifo_pkg.sv ====
// shared definitions for the single-clock fifo.
// word and depth sizes, pointer and count widths,
// and the per-cycle operation code of the pointer tracker.

`default_nettype none

package fifo_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int fifo_width_lp = 16;                  // bits per word.
    localparam int fifo_depth_lp = 32;                  // entries, a power of two.

    // pointers wrap naturally at the depth.
    localparam int fifo_addr_width_lp = $clog2(fifo_depth_lp);

    // one extra bit so that a full queue is representable.
    localparam int fifo_count_width_lp = fifo_addr_width_lp + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation code
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // effective operation of one cycle, after the
    // full and empty checks have been applied.
    typedef enum logic [1:0]
    {
        op_idle     = 2'b00,
        op_push     = 2'b01,
        op_pop      = 2'b10,
        op_push_pop = 2'b11
    } fifo_op_e;

endpackage : fifo_pkg

`default_nettype wire

// ==== hdl/mem_1r1w.sv ====
// register file with one write port and one read port.
// writes are synchronous, reads are asynchronous.

`timescale 1ns/1ns
`default_nettype none

module mem_1r1w
    import fifo_pkg::*;
(
    input  wire                           w_clk_i,

    // write port.
    input  wire                           w_v_i,
    input  wire [fifo_addr_width_lp-1:0]  w_addr_i,
    input  wire [fifo_width_lp-1:0]       w_data_i,

    // read port.
    input  wire [fifo_addr_width_lp-1:0]  r_addr_i,
    output logic [fifo_width_lp-1:0]      r_data_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // plain inferred cells, one word per entry.
    logic [fifo_width_lp-1:0] mem_r [fifo_depth_lp];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the word lands at the edge, so a read of the
    // same address still sees the old contents until then.
    always_ff @(posedge w_clk_i)
    begin
        if (w_v_i)
        begin
            mem_r[w_addr_i] <= w_data_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // zero latency, head of queue always visible.
    assign r_data_o = mem_r[r_addr_i];

endmodule : mem_1r1w

`default_nettype wire

// ==== hdl/fifo_ptr_tracker.sv ====
// pointer tracker for the single-clock fifo.
// decodes push and pop strobes into one operation per cycle,
// steps the write and read pointers, keeps the fill count,
// registers full and empty, and pulses on dropped strobes.

`timescale 1ns/1ns
`default_nettype none

module fifo_ptr_tracker
    import fifo_pkg::*;
(
    input  wire                            w_clk_i,
    input  wire                            arst_n_i,

    // strobes from the producer and the consumer.
    input  wire                            push_i,
    input  wire                            pop_i,

    // register file control, combinational.
    output logic                           w_v_o,
    output logic [fifo_addr_width_lp-1:0]  w_addr_o,
    output logic [fifo_addr_width_lp-1:0]  r_addr_o,

    // registered status.
    output logic [fifo_count_width_lp-1:0] count_o,
    output logic                           full_o,
    output logic                           empty_o,
    output logic                           overflow_o,
    output logic                           underflow_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [fifo_addr_width_lp-1:0]  wr_ptr_q;
    logic [fifo_addr_width_lp-1:0]  rd_ptr_q;
    logic [fifo_count_width_lp-1:0] count_q;
    logic                           full_q;
    logic                           empty_q;
    logic                           overflow_q;
    logic                           underflow_q;

    // next-state values.
    logic [fifo_addr_width_lp-1:0]  wr_ptr_next;
    logic [fifo_addr_width_lp-1:0]  rd_ptr_next;
    logic [fifo_count_width_lp-1:0] count_next;

    // accepted strobes and the resulting operation.
    logic     push_ok;
    logic     pop_ok;
    fifo_op_e op;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // accept and decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // decisions use the state at the start of the cycle,
    // so a pop never frees room for a push in the same cycle.
    assign push_ok = push_i & ~full_q;
    assign pop_ok  = pop_i & ~empty_q;

    always_comb
    begin
        case ({pop_ok, push_ok})
            2'b01:   op = op_push;
            2'b10:   op = op_pop;
            2'b11:   op = op_push_pop;
            default: op = op_idle;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // pointers wrap at the power-of-two depth.
    always_comb
    begin
        wr_ptr_next = wr_ptr_q;
        rd_ptr_next = rd_ptr_q;
        count_next  = count_q;

        case (op)
            op_push:
            begin
                wr_ptr_next = wr_ptr_q + 1'b1;
                count_next  = count_q + 1'b1;
            end
            op_pop:
            begin
                rd_ptr_next = rd_ptr_q + 1'b1;
                count_next  = count_q - 1'b1;
            end
            op_push_pop:
            begin
                wr_ptr_next = wr_ptr_q + 1'b1;     // count holds.
                rd_ptr_next = rd_ptr_q + 1'b1;
            end
            default:
            begin
                count_next = count_q;              // idle.
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge w_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            full_q      <= 1'b0;
            empty_q     <= 1'b1;                   // starts empty.
            overflow_q  <= 1'b0;
            underflow_q <= 1'b0;
        end
        else
        begin
            wr_ptr_q    <= wr_ptr_next;
            rd_ptr_q    <= rd_ptr_next;
            count_q     <= count_next;
            full_q      <= (count_next == fifo_count_width_lp'(fifo_depth_lp));
            empty_q     <= (count_next == '0);
            overflow_q  <= push_i & full_q;        // dropped push.
            underflow_q <= pop_i & empty_q;        // ignored pop.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // write strobe already carries the full check.
    assign w_v_o    = push_ok;
    assign w_addr_o = wr_ptr_q;
    assign r_addr_o = rd_ptr_q;                    // head of queue.

    assign count_o     = count_q;
    assign full_o      = full_q;
    assign empty_o     = empty_q;
    assign overflow_o  = overflow_q;
    assign underflow_o = underflow_q;

endmodule : fifo_ptr_tracker

`default_nettype wire

// ==== hdl/fifo_1r1w.sv ====
// top level of the single-clock fifo.
// pointer tracker driving a 1r1w register file.

`timescale 1ns/1ns
`default_nettype none

module fifo_1r1w
    import fifo_pkg::*;
(
    input  wire                            w_clk_i,
    input  wire                            arst_n_i,

    // producer side.
    input  wire                            push_i,
    input  wire [fifo_width_lp-1:0]        w_data_i,

    // consumer side.
    input  wire                            pop_i,
    output logic [fifo_width_lp-1:0]       r_data_o,

    // status.
    output logic [fifo_count_width_lp-1:0] count_o,
    output logic                           full_o,
    output logic                           empty_o,
    output logic                           overflow_o,
    output logic                           underflow_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal wiring
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                          mem_w_v;
    logic [fifo_addr_width_lp-1:0] mem_w_addr;
    logic [fifo_addr_width_lp-1:0] mem_r_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointer tracker
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fifo_ptr_tracker u_tracker
    (
        .w_clk_i     (w_clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (push_i),
        .pop_i       (pop_i),
        .w_v_o       (mem_w_v),
        .w_addr_o    (mem_w_addr),
        .r_addr_o    (mem_r_addr),
        .count_o     (count_o),
        .full_o      (full_o),
        .empty_o     (empty_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // data goes straight in, head comes straight out.
    mem_1r1w u_mem
    (
        .w_clk_i  (w_clk_i),
        .w_v_i    (mem_w_v),
        .w_addr_i (mem_w_addr),
        .w_data_i (w_data_i),
        .r_addr_i (mem_r_addr),
        .r_data_o (r_data_o)
    );

endmodule : fifo_1r1w

`default_nettype wire

// ==== verification/fifo_props.sv ====
// concurrent assertions on the fifo pointer tracker.
// full and empty exclusion, count bound, no write while full,
// and the overflow pulse after a dropped push.

`timescale 1ns/1ns
`default_nettype none

module fifo_props
    import fifo_pkg::*;
(
    input wire                           w_clk_i,
    input wire                           arst_n_i,
    input wire                           push_i,
    input wire                           w_v_i,
    input wire [fifo_count_width_lp-1:0] count_i,
    input wire                           full_i,
    input wire                           empty_i,
    input wire                           overflow_i
);

    a_full_empty_excl: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
        !(full_i && empty_i))
        else $error("full_o and empty_o are high in the same cycle");

    a_count_bound: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
        count_i <= fifo_count_width_lp'(fifo_depth_lp))
        else $error("count_o is above the queue depth");

    // the write strobe must already carry the full check.
    a_no_write_full: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
        !(w_v_i && full_i))
        else $error("write strobe is high while the queue is full");

    a_overflow_pulse: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
        (push_i && full_i) |=> overflow_i)
        else $error("overflow_o did not follow a push made while full");

endmodule : fifo_props

`default_nettype wire

// ==== verification/fifo_checker.sv ====
// cycle checker for the fifo.
// queue model of the acceptance rules, compare of the status
// outputs and the head word each cycle, error and check counts.

`timescale 1ns/1ns
`default_nettype none

module fifo_checker
    import fifo_pkg::*;
(
    input  wire                           w_clk_i,
    input  wire                           arst_n_i,
    input  wire                           push_i,
    input  wire                           pop_i,
    input  wire [fifo_width_lp-1:0]       w_data_i,
    input  wire [fifo_width_lp-1:0]       r_data_i,
    input  wire [fifo_count_width_lp-1:0] count_i,
    input  wire                           full_i,
    input  wire                           empty_i,
    input  wire                           overflow_i,
    input  wire                           underflow_i,
    output int                            error_count_o,
    output int                            check_count_o
);

    logic [fifo_width_lp-1:0] model_q [$];
    logic                     exp_overflow;
    logic                     exp_underflow;
    fifo_op_e                 op;
    int                       errors = 0;
    int                       checks = 0;

    assign error_count_o = errors;
    assign check_count_o = checks;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    function automatic fifo_op_e decode_op(input logic push_ok, input logic pop_ok);
        if (push_ok && pop_ok)
            return op_push_pop;
        else if (push_ok)
            return op_push;
        else if (pop_ok)
            return op_pop;
        else
            return op_idle;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs and strobes are stable mid-cycle.
    always @(negedge w_clk_i)
    begin
        if (arst_n_i !== 1'b1)             // also while still unknown.
        begin
            model_q.delete();
            exp_overflow  = 1'b0;
            exp_underflow = 1'b0;
        end
        else
        begin
            compare_value("count_o", 32'(model_q.size()), 32'(count_i));
            compare_value("full_o", 32'(model_q.size() == fifo_depth_lp), 32'(full_i));
            compare_value("empty_o", 32'(model_q.size() == 0), 32'(empty_i));
            compare_value("overflow_o", 32'(exp_overflow), 32'(overflow_i));
            compare_value("underflow_o", 32'(exp_underflow), 32'(underflow_i));
            if (!empty_i && model_q.size() != 0)
                compare_value("r_data_o", 32'(model_q[0]), 32'(r_data_i));

            // these strobes are taken at the next rising edge.
            exp_overflow  = push_i && (model_q.size() == fifo_depth_lp);
            exp_underflow = pop_i && (model_q.size() == 0);
            op = decode_op(push_i && (model_q.size() < fifo_depth_lp),
                           pop_i && (model_q.size() != 0));
            case (op)
                op_push:     model_q.push_back(w_data_i);
                op_pop:      void'(model_q.pop_front());
                op_push_pop:
                begin
                    void'(model_q.pop_front());  // never empty here.
                    model_q.push_back(w_data_i);
                end
                default: ;
            endcase
        end
    end

endmodule : fifo_checker

`default_nettype wire

// ==== verification/fifo_tb.sv ====
// testbench top for the single-clock fifo.
// clock, reset, lfsr stimulus, test sequence, watchdog,
// checker instance and the bind of the tracker assertions.

`timescale 1ns/1ns
`default_nettype none

module fifo_tb
    import fifo_pkg::*;
();

    localparam int random_cycles_lp = 4000;
    localparam int total_cycles_lp  = 10 + 6 + 2 * (fifo_depth_lp + 16) + 52
                                      + random_cycles_lp + 10;
    localparam int watchdog_ns_lp   = (total_cycles_lp + 200) * 20;

    logic                           w_clk_i;
    logic                           arst_n_i;
    logic                           push_i;
    logic                           pop_i;
    logic [fifo_width_lp-1:0]       w_data_i;
    logic [fifo_width_lp-1:0]       r_data_o;
    logic [fifo_count_width_lp-1:0] count_o;
    logic                           full_o;
    logic                           empty_o;
    logic                           overflow_o;
    logic                           underflow_o;
    int                             error_count;
    int                             check_count;
    int                             tb_failures = 0;
    int                             errors_before = 0;
    int                             test_num = 0;
    logic [31:0]                    lfsr_state;

    fifo_1r1w uut
    (
        .w_clk_i     (w_clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (push_i),
        .w_data_i    (w_data_i),
        .pop_i       (pop_i),
        .r_data_o    (r_data_o),
        .count_o     (count_o),
        .full_o      (full_o),
        .empty_o     (empty_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

    fifo_checker u_checker
    (
        .w_clk_i       (w_clk_i),
        .arst_n_i      (arst_n_i),
        .push_i        (push_i),
        .pop_i         (pop_i),
        .w_data_i      (w_data_i),
        .r_data_i      (r_data_o),
        .count_i       (count_o),
        .full_i        (full_o),
        .empty_i       (empty_o),
        .overflow_i    (overflow_o),
        .underflow_i   (underflow_o),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

    bind fifo_ptr_tracker fifo_props u_props
    (
        .w_clk_i    (w_clk_i),
        .arst_n_i   (arst_n_i),
        .push_i     (push_i),
        .w_v_i      (w_v_o),
        .count_i    (count_o),
        .full_i     (full_o),
        .empty_i    (empty_o),
        .overflow_i (overflow_o)
    );

    initial
    begin
        w_clk_i = 1'b0;
        forever #10 w_clk_i = ~w_clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // galois lfsr, one step per bit.
    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic drive_cycle(input logic push, input logic pop,
                               input logic [fifo_width_lp-1:0] data);
        @(posedge w_clk_i);
        push_i   <= push;
        pop_i    <= pop;
        w_data_i <= data;
    endtask

    task automatic wait_for_flag(input logic want_full, input int max_cycles);
        int n;
        n = 0;
        @(negedge w_clk_i);
        while (n < max_cycles && (want_full ? !full_o : !empty_o))
        begin
            @(negedge w_clk_i);
            n++;
        end
        if (want_full ? !full_o : !empty_o)
        begin
            tb_failures++;
            $display("%s did not rise within %0d cycles",
                     want_full ? "full_o" : "empty_o", max_cycles);
        end
    endtask

    task automatic end_test(input string name);
        int now_errors;
        drive_cycle(1'b0, 1'b0, '0);
        repeat (2) @(posedge w_clk_i);   // let the checker see the last cycle.
        now_errors = error_count + tb_failures;
        test_num++;
        $display("test %0d %s finished with %0d errors",
                 test_num, name, now_errors - errors_before);
        errors_before = now_errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fill_and_overflow();
        for (int i = 0; i < fifo_depth_lp; i++)
        begin
            drive_cycle(1'b1, 1'b0, fifo_width_lp'(random_bits(fifo_width_lp)));
        end
        drive_cycle(1'b0, 1'b0, '0);
        wait_for_flag(1'b1, 4);
        repeat (4) drive_cycle(1'b1, 1'b0, fifo_width_lp'(random_bits(fifo_width_lp)));
    endtask

    task automatic drain_and_underflow();
        repeat (fifo_depth_lp) drive_cycle(1'b0, 1'b1, '0);
        drive_cycle(1'b0, 1'b0, '0);
        wait_for_flag(1'b0, 4);
        repeat (4) drive_cycle(1'b0, 1'b1, '0);
    endtask

    task automatic overlap_push_pop();
        repeat (8) drive_cycle(1'b1, 1'b0, fifo_width_lp'(random_bits(fifo_width_lp)));
        repeat (16) drive_cycle(1'b1, 1'b1, fifo_width_lp'(random_bits(fifo_width_lp)));
        repeat (8) drive_cycle(1'b0, 1'b1, '0);
        drive_cycle(1'b0, 1'b0, '0);
        wait_for_flag(1'b0, 4);
    endtask

    task automatic run_random_mix();
        logic                     fill_bias;
        logic [1:0]               push_roll;
        logic [1:0]               pop_roll;
        logic [fifo_width_lp-1:0] data;
        for (int i = 0; i < random_cycles_lp; i++)
        begin
            fill_bias = ((i / 250) % 2) == 0;   // alternate filling and draining.
            push_roll = 2'(random_bits(2));
            pop_roll  = 2'(random_bits(2));
            data      = fifo_width_lp'(random_bits(fifo_width_lp));
            if (fill_bias)
                drive_cycle(push_roll != 2'b00, pop_roll == 2'b00, data);
            else
                drive_cycle(push_roll == 2'b00, pop_roll != 2'b00, data);
        end
    endtask

    initial
    begin
        #(watchdog_ns_lp);
        $display("Timeout: the tests did not finish within %0d cycles", total_cycles_lp);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        lfsr_state = 32'h44f4_50ab;
        arst_n_i   = 1'b0;
        push_i     = 1'b0;
        pop_i      = 1'b0;
        w_data_i   = '0;
        repeat (10) @(posedge w_clk_i);
        arst_n_i <= 1'b1;

        repeat (4) drive_cycle(1'b0, 1'b0, '0);
        end_test("reset values");
        fill_and_overflow();
        end_test("fill and overflow");
        drain_and_underflow();
        end_test("drain and underflow");
        overlap_push_pop();
        end_test("push and pop together");
        run_random_mix();
        end_test("random mix");

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_num, check_count, error_count + tb_failures);
        if (error_count + tb_failures == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule : fifo_tb

`default_nettype wire

// ==== flist.f ====
hdl/fifo_pkg.sv
hdl/mem_1r1w.sv
hdl/fifo_ptr_tracker.sv
hdl/fifo_1r1w.sv
verification/fifo_props.sv
verification/fifo_checker.sv
verification/fifo_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fifo testbench with verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module fifo_tb \
    -Mdir obj_dir

# the testbench decides the result, so keep its output either way.
output=$(./obj_dir/Vfifo_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"
then
    exit 0
else
    echo "run.sh: pass message not found in the simulation output"
    exit 1
fi
